//--- bench/decode_checker.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module decode_checker
  import decode_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   in_valid,
  input  logic [`DEC_INSN_W-1:0] insn,
  input  logic                   out_valid,
  input  decoded_t               out,
  input  logic                   drain_check,
  output int                     value_errs,
  output int                     other_errs
);

  // expected results and the edge each instruction was sampled on
  decoded_t exp_q[$];
  int       cyc_q[$];

  int   n_value = 0;
  int   n_other = 0;
  int   edge_cnt = 0;
  logic rst_d1 = 1'b0;
  logic rst_d2 = 1'b0;
  logic drained = 1'b0;

  assign value_errs = n_value;
  assign other_errs = n_other;

  // legal opcode group / funct3 pairs, listed per major opcode
  function automatic logic pair_legal(input logic [4:0] grp, input logic [2:0] f3);
    case (grp)
      5'b00000: pair_legal = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
      5'b00010: pair_legal = (f3 == 3'd0);
      5'b00011: pair_legal = f3 inside {3'd0, 3'd1};
      5'b00100, 5'b00101, 5'b01100, 5'b01101, 5'b11011: pair_legal = 1'b1;
      5'b01000: pair_legal = f3 inside {3'd0, 3'd1, 3'd2};
      5'b11000: pair_legal = !(f3 inside {3'd2, 3'd3});
      5'b11001: pair_legal = (f3 == 3'd0);
      5'b11100: pair_legal = (f3 != 3'd4);
      default:  pair_legal = 1'b0;
    endcase
  endfunction

  // reference decode of one instruction word
  function automatic decoded_t expect_decode(input logic [`DEC_INSN_W-1:0] w);
    logic [4:0] grp;
    logic [2:0] f3;
    logic       quad;
    logic       mul_div;
    decoded_t   d;
    grp     = w[6:2];
    f3      = w[14:12];
    quad    = (w[1:0] == 2'b11);
    mul_div = (w[31:25] == 7'b0000001) && (grp == 5'b01100);
    d.ill   = !quad || (!mul_div && !pair_legal(grp, f3));
    if (d.ill) begin
      d.mext  = 1'b0;
      d.entry = `DEC_ILL_ENTRY;
    end else if (mul_div) begin
      d.mext  = 1'b1;
      d.entry = {`DEC_MEXT_BASE, f3};
    end else begin
      d.mext  = 1'b0;
      d.entry = {grp, f3};
    end
    return d;
  endfunction

  // everything is sampled on the rising edge, inputs settle 1 ns after it
  always @(posedge clk) begin : watch
    decoded_t exp_d;
    int       sent_at;
    // out_valid must be low while reset is seen and one edge later
    if ((rst_d1 || rst_d2) && out_valid !== 1'b0) begin
      $display("out_valid was not low during or right after reset at %0t", $time);
      n_other++;
    end
    if (!rst && out_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("output at %0t with no instruction in flight", $time);
        n_other++;
      end else begin
        exp_d   = exp_q.pop_front();
        sent_at = cyc_q.pop_front();
        if (edge_cnt - sent_at != `DEC_PIPE_DEPTH) begin
          $display("ERR %0t latency expected %0d got %0d", $time,
                   `DEC_PIPE_DEPTH, edge_cnt - sent_at);
          n_value++;
        end
        if (out.ill !== exp_d.ill) begin
          $display("ERR %0t out.ill expected %0b got %0b", $time, exp_d.ill, out.ill);
          n_value++;
        end
        if (out.mext !== exp_d.mext) begin
          $display("ERR %0t out.mext expected %0b got %0b", $time, exp_d.mext, out.mext);
          n_value++;
        end
        if (out.entry !== exp_d.entry) begin
          $display("ERR %0t out.entry expected %h got %h", $time, exp_d.entry, out.entry);
          n_value++;
        end
      end
    end
    if (!rst && in_valid === 1'b1) begin
      exp_q.push_back(expect_decode(insn));
      cyc_q.push_back(edge_cnt);
    end
    // end of run, everything sent must have come out
    if (drain_check && !drained) begin
      if (exp_q.size() != 0) begin
        $display("%0d instructions never came out of the pipeline", exp_q.size());
        n_other++;
      end
      drained = 1'b1;
    end
    rst_d2   <= rst_d1;
    rst_d1   <= rst;
    edge_cnt <= edge_cnt + 1;
  end

endmodule

//--- bench/decode_tb.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module decode_tb
  import decode_pkg::*;
;

  localparam int NUM_INSN    = 2000;
  localparam int IDLE_CYC    = 10;
  // average is about 4/3 cycles per instruction
  // 2 per instruction plus 100 leaves room for reset and drain
  localparam int TIMEOUT_CYC = NUM_INSN * 2 + 100;
  localparam logic [31:0] SEED = 32'h68342bcf;

  logic                   clk;
  logic                   rst;
  logic                   in_valid;
  logic [`DEC_INSN_W-1:0] insn;
  logic                   out_valid;
  decoded_t               out;
  logic                   drain_check;
  int                     value_errs;
  int                     other_errs;
  logic [31:0]            seed;
  int                     sent;

  decode_top dut_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .insn      (insn),
    .out_valid (out_valid),
    .out       (out)
  );

  decode_checker chk_i (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .insn        (insn),
    .out_valid   (out_valid),
    .out         (out),
    .drain_check (drain_check),
    .value_errs  (value_errs),
    .other_errs  (other_errs)
  );

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // numerical recipes LCG constants
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // kind 0 is a raw word
  // kinds 1 and 2 have low bits 11 and any opcode
  // kind 3 is a mul/div OP word
  task automatic draw_insn(input logic [1:0] kind, output logic [31:0] w);
    logic [31:0] r;
    seed = lcg_next(seed);
    w    = seed;
    seed = lcg_next(seed);
    r    = seed;
    if (kind == 2'd1 || kind == 2'd2) begin
      w[1:0]   = 2'b11;
      w[6:2]   = r[31:27];
      w[14:12] = r[26:24];
    end else if (kind == 2'd3) begin
      w[31:25] = 7'b0000001;
      w[6:0]   = 7'b0110011;
    end
  endtask

  initial begin : stimulus
    logic [31:0] w;
    rst         = 1'b1;
    in_valid    = 1'b0;
    insn        = '0;
    drain_check = 1'b0;
    seed        = SEED;
    sent        = 0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    while (sent < NUM_INSN) begin
      seed = lcg_next(seed);
      // upper bits give valid about 3 times in 4
      if (seed[31:30] != 2'b00) begin
        draw_insn(seed[29:28], w);
        insn     = w;
        in_valid = 1'b1;
        sent++;
      end else begin
        // junk on insn during a bubble must not produce an output
        insn     = seed;
        in_valid = 1'b0;
      end
      @(posedge clk);
      #1;
    end
    in_valid = 1'b0;
    repeat (IDLE_CYC) @(posedge clk);
    #1;
    drain_check = 1'b1;
    @(posedge clk);
    #1;
    $display("sent %0d instructions, %0d value errors, %0d other errors",
             sent, value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // cycle counter against a hang
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYC) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, run did not end within %0d cycles", TIMEOUT_CYC);
    $display("Finished with errors");
    $finish;
  end

endmodule

//--- logic/decode_macros.svh
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// raw instruction word width
`define DEC_INSN_W 32

// major opcode field (bits 6:2) and funct3 field widths
`define DEC_GROUP_W 5
`define DEC_F3_W 3

// microcode entry address width, opcode group over funct3
`define DEC_ENTRY_W 8

// single entry where every illegal instruction lands
`define DEC_ILL_ENTRY 8'h99
// free opcode slot reused for the multiply/divide entries
`define DEC_MEXT_BASE 5'b10000

// stages from insn to out
`define DEC_PIPE_DEPTH 3

`endif

//--- logic/decode_pkg.sv
`include "decode_macros.svh"

package decode_pkg;

  // major opcode groups, instruction bits 6:2
  // unlisted codes may still appear on the wire, they decode as illegal
  typedef enum logic [`DEC_GROUP_W-1:0] {
    GRP_LOAD     = 5'b00000,
    GRP_CUSTOM0  = 5'b00010,
    GRP_MISC_MEM = 5'b00011,
    GRP_OP_IMM   = 5'b00100,
    GRP_AUIPC    = 5'b00101,
    GRP_STORE    = 5'b01000,
    GRP_OP       = 5'b01100,
    GRP_LUI      = 5'b01101,
    GRP_BRANCH   = 5'b11000,
    GRP_JALR     = 5'b11001,
    GRP_JAL      = 5'b11011,
    GRP_SYSTEM   = 5'b11100
  } op_group_e;

  // stage 1 result, the fields the later stages need
  typedef struct packed {
    op_group_e             group;
    logic [`DEC_F3_W-1:0]  funct3;
    // low two bits are 11, i.e. not a compressed encoding
    logic                  quad_ok;
    // OP group with funct7 0000001
    logic                  mext;
  } fields_t;

  // stage 2 result
  typedef struct packed {
    fields_t fld;
    logic    ill;
  } legal_t;

  // stage 3 result, leaves the pipeline
  typedef struct packed {
    logic                    ill;
    logic                    mext;
    logic [`DEC_ENTRY_W-1:0] entry;
  } decoded_t;

endpackage

//--- logic/decode_top.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

// instruction pre-decode, `DEC_PIPE_DEPTH registered stages
// extract -> legality -> entry select, one register after each
module decode_top
  import decode_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   in_valid,
  input  logic [`DEC_INSN_W-1:0] insn,
  output logic                   out_valid,
  output decoded_t               out
);

  fields_t  s1_d;
  fields_t  s1_q;
  logic     s1_valid;
  legal_t   s2_d;
  legal_t   s2_q;
  logic     s2_valid;
  decoded_t s3_d;

  // stage 1, split and classify the raw word
  field_extract u_extract (
    .insn   (insn),
    .fields (s1_d)
  );

  pipe_reg #(.payload_t(fields_t)) s1_reg (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_data   (s1_d),
    .out_valid (s1_valid),
    .out_data  (s1_q)
  );

  // stage 2, legality table
  legality_check u_legal (
    .fields (s1_q),
    .legal  (s2_d)
  );

  pipe_reg #(.payload_t(legal_t)) s2_reg (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (s1_valid),
    .in_data   (s2_d),
    .out_valid (s2_valid),
    .out_data  (s2_q)
  );

  // stage 3, microcode entry address
  entry_select u_entry (
    .legal (s2_q),
    .dec   (s3_d)
  );

  // output register, no back-pressure
  pipe_reg #(.payload_t(decoded_t)) s3_reg (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (s2_valid),
    .in_data   (s3_d),
    .out_valid (out_valid),
    .out_data  (out)
  );

endmodule

//--- logic/entry_select.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module entry_select
  import decode_pkg::*;
(
  input  legal_t   legal,
  output decoded_t dec
);

  logic [`DEC_ENTRY_W-1:0] norm_entry;
  logic [`DEC_ENTRY_W-1:0] mext_entry;
  logic                    mext_ok;

  // plain entry, group over funct3
  assign norm_entry = {legal.fld.group, legal.fld.funct3};

  // mul/div sit in the otherwise unused 10000 slot
  assign mext_entry = {`DEC_MEXT_BASE, legal.fld.funct3};

  // an illegal word never claims to be a mul/div
  assign mext_ok = legal.fld.mext && !legal.ill;

  always_comb begin
    dec.ill  = legal.ill;
    dec.mext = mext_ok;
    if (legal.ill) begin
      // one shared trap entry
      dec.entry = `DEC_ILL_ENTRY;
    end else if (mext_ok) begin
      dec.entry = mext_entry;
    end else begin
      dec.entry = norm_entry;
    end
  end

endmodule

//--- logic/field_extract.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module field_extract
  import decode_pkg::*;
(
  input  logic [`DEC_INSN_W-1:0] insn,
  output fields_t                fields
);

  // funct7 pattern of the M extension
  localparam logic [6:0] MEXT_F7 = 7'b0000001;

  logic [`DEC_GROUP_W-1:0] opc;
  logic [`DEC_F3_W-1:0]    f3;
  logic [6:0]              f7;
  logic [1:0]              quad;

  // raw slices
  assign opc  = insn[6:2];
  assign f3   = insn[14:12];
  assign f7   = insn[31:25];
  assign quad = insn[1:0];

  always_comb begin
    // cast keeps unlisted opcodes as they are, stage 2 rejects them
    fields.group  = op_group_e'(opc);
    fields.funct3 = f3;
    // only 32-bit encodings are handled, no C expansion here
    fields.quad_ok = (quad == 2'b11);
    // mul/div go to the microcoded entries
    // funct7 is only looked at here, bad shift encodings pass through
    fields.mext = (f7 == MEXT_F7) && (opc == GRP_OP);
  end

endmodule

//--- logic/legality_check.sv
`timescale 1ns/1ps

module legality_check
  import decode_pkg::*;
(
  input  fields_t fields,
  output legal_t  legal
);

  logic tab_ill;

  // opcode/funct3 pairs that would land on a busy microcode location
  // unassigned groups fall to the default and count as illegal
  always_comb begin
    casez ({fields.group, fields.funct3})
      // load: LB LH LW LBU LHU
      8'b00000_00? : tab_ill = 1'b0;
      8'b00000_010 : tab_ill = 1'b0;
      8'b00000_011 : tab_ill = 1'b1;
      8'b00000_10? : tab_ill = 1'b0;
      8'b00000_11? : tab_ill = 1'b1;

      // custom0, only funct3 0
      8'b00010_000 : tab_ill = 1'b0;
      8'b00010_001 : tab_ill = 1'b1;
      8'b00010_01? : tab_ill = 1'b1;
      8'b00010_1?? : tab_ill = 1'b1;

      // misc_mem: FENCE, FENCE.I
      8'b00011_00? : tab_ill = 1'b0;
      8'b00011_01? : tab_ill = 1'b1;
      8'b00011_1?? : tab_ill = 1'b1;

      // op_imm and auipc, every funct3
      8'b0010?_??? : tab_ill = 1'b0;

      // store: SB SH SW
      8'b01000_00? : tab_ill = 1'b0;
      8'b01000_010 : tab_ill = 1'b0;
      8'b01000_011 : tab_ill = 1'b1;
      8'b01000_1?? : tab_ill = 1'b1;

      // op and lui, every funct3
      8'b0110?_??? : tab_ill = 1'b0;

      // branch: 2 and 3 have no compare
      8'b11000_00? : tab_ill = 1'b0;
      8'b11000_01? : tab_ill = 1'b1;
      8'b11000_1?? : tab_ill = 1'b0;

      // jalr, only funct3 0
      8'b11001_000 : tab_ill = 1'b0;
      8'b11001_001 : tab_ill = 1'b1;
      8'b11001_01? : tab_ill = 1'b1;
      8'b11001_1?? : tab_ill = 1'b1;

      // jal, funct3 is immediate bits
      8'b11011_??? : tab_ill = 1'b0;

      // system: ECALL/EBREAK and CSR ops, 4 is unused
      8'b11100_0?? : tab_ill = 1'b0;
      8'b11100_100 : tab_ill = 1'b1;
      8'b11100_101 : tab_ill = 1'b0;
      8'b11100_11? : tab_ill = 1'b0;

      default      : tab_ill = 1'b1;
    endcase
  end

  always_comb begin
    legal.fld = fields;
    // M ops take any funct3, bad quadrant overrides everything
    legal.ill = !fields.quad_ok || (tab_ill && !fields.mext);
  end

endmodule

//--- logic/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  // valid follows the upstream strobe every cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // payload only moves with a valid beat
  // bubbles leave the last value in place, no toggling
  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_data <= in_data;
    end
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -f verilog.f --top-module decode_tb -o decode_sim

./obj_dir/decode_sim > sim.log 2>&1
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

//--- verilog.f
+incdir+logic
logic/decode_pkg.sv
logic/pipe_reg.sv
logic/field_extract.sv
logic/legality_check.sv
logic/entry_select.sv
logic/decode_top.sv
bench/decode_checker.sv
bench/decode_tb.sv
